//--- Makefile
VERILATOR ?= verilator
TOP ?= clb_tile_tb
BUILD_DIR ?= obj_dir
LOG ?= sim.log
FILELIST ?= all.f
VFLAGS ?= --binary --timing --assert -Wno-fatal

SOURCES := $(shell grep -v '^+' $(FILELIST))
BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: all run clean

all: run

$(BIN): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(BIN)
	./$(BIN) > $(LOG) 2>&1; cat $(LOG)
	grep -q "All checks passed" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- all.f
source/fabric_pkg.sv
source/logic_slice.sv
source/connection_block.sv
source/switch_box.sv
source/clb_tile.sv
testbench/clb_tile_asserts.sv
testbench/clb_tile_tb.sv

//--- source/clb_tile.sv
`timescale 1ns/1ns

module clb_tile #(
  parameter int ws = 4
) (
  input  logic                 clk,
  input  logic                 arst_n,
  input  logic                 cen,
  input  logic                 cfg_set,
  input  logic                 cfg_in,
  output logic                 cfg_out,

  input  logic [ws-1:0]        north_single_in,
  input  logic [ws-1:0]        east_single_in,
  input  logic [ws-1:0]        south_single_in,
  input  logic [ws-1:0]        west_single_in,
  output logic [ws-1:0]        north_single_out,
  output logic [ws-1:0]        east_single_out,
  output logic [ws-1:0]        south_single_out,
  output logic [ws-1:0]        west_single_out,

  // CLBs of the north and east neighbors reach this tile's connection blocks
  input  fabric_pkg::clb_out_t cb_north_in,
  input  fabric_pkg::clb_out_t cb_east_in,
  output fabric_pkg::lut_in_t  cb_north_out,
  output fabric_pkg::lut_in_t  cb_east_out,

  // This CLB reaches the connection blocks of the south and west neighbors
  input  fabric_pkg::lut_in_t  clb_south_in,
  input  fabric_pkg::lut_in_t  clb_west_in,
  output fabric_pkg::clb_out_t clb_south_out,
  output fabric_pkg::clb_out_t clb_west_out
);

  // Chain order is slice, cb_north, sb, cb_east
  logic slice_cfg_out;
  logic cb_north_cfg_out;
  logic sb_cfg_out;

  logic [ws-1:0] sb_west_in;
  logic [ws-1:0] sb_west_out;
  logic [ws-1:0] sb_south_in;
  logic [ws-1:0] sb_south_out;

  fabric_pkg::lut_in_t  slice_north_in;
  fabric_pkg::lut_in_t  slice_east_in;
  fabric_pkg::clb_out_t slice_north_out;
  fabric_pkg::clb_out_t slice_east_out;

  logic_slice slice (
    .clk(clk), .arst_n(arst_n), .cen(cen), .cfg_set(cfg_set),
    .cfg_in(cfg_in), .cfg_out(slice_cfg_out),
    .north_in(slice_north_in), .east_in(slice_east_in),
    .south_in(clb_south_in), .west_in(clb_west_in),
    .north_out(slice_north_out), .east_out(slice_east_out),
    .south_out(clb_south_out), .west_out(clb_west_out)
  );

  // West tracks on track0, switch box west side on track1
  connection_block #(.ws(ws)) cb_north (
    .clk(clk), .arst_n(arst_n), .cen(cen), .cfg_set(cfg_set),
    .cfg_in(slice_cfg_out), .cfg_out(cb_north_cfg_out),
    .track0_in(west_single_in), .track0_out(west_single_out),
    .track1_in(sb_west_out), .track1_out(sb_west_in),
    .clb0_out(slice_north_out), .clb1_out(cb_north_in),
    .clb0_in(slice_north_in), .clb1_in(cb_north_out)
  );

  switch_box #(.ws(ws)) sb (
    .clk(clk), .arst_n(arst_n), .cen(cen), .cfg_set(cfg_set),
    .cfg_in(cb_north_cfg_out), .cfg_out(sb_cfg_out),
    .north_in(north_single_in), .east_in(east_single_in),
    .south_in(sb_south_in), .west_in(sb_west_in),
    .north_out(north_single_out), .east_out(east_single_out),
    .south_out(sb_south_out), .west_out(sb_west_out)
  );

  // South tracks on track0, switch box south side on track1
  connection_block #(.ws(ws)) cb_east (
    .clk(clk), .arst_n(arst_n), .cen(cen), .cfg_set(cfg_set),
    .cfg_in(sb_cfg_out), .cfg_out(cfg_out),
    .track0_in(south_single_in), .track0_out(south_single_out),
    .track1_in(sb_south_out), .track1_out(sb_south_in),
    .clb0_out(slice_east_out), .clb1_out(cb_east_in),
    .clb0_in(slice_east_in), .clb1_in(cb_east_out)
  );

endmodule

//--- source/connection_block.sv
`timescale 1ns/1ns

module connection_block #(
  parameter int ws = 4
) (
  input  logic                 clk,
  input  logic                 arst_n,
  input  logic                 cen,
  input  logic                 cfg_set,
  input  logic                 cfg_in,
  output logic                 cfg_out,
  input  logic [ws-1:0]        track0_in,
  input  logic [ws-1:0]        track1_in,
  output logic [ws-1:0]        track0_out,
  output logic [ws-1:0]        track1_out,
  input  fabric_pkg::clb_out_t clb0_out,
  input  fabric_pkg::clb_out_t clb1_out,
  output fabric_pkg::lut_in_t  clb0_in,
  output fabric_pkg::lut_in_t  clb1_in
);

  localparam int in_sel_bits = $clog2(2 * ws);
  localparam int num_in_sels = 2 * fabric_pkg::num_luts;
  localparam int out_sel_bits = $bits(fabric_pkg::cb_out_sel_t);
  // Output selects start right after the input selects
  localparam int out_base = num_in_sels * in_sel_bits;
  localparam int cfg_bits = out_base + 2 * ws * out_sel_bits;

  typedef logic [in_sel_bits-1:0] cb_in_sel_t;

  logic [cfg_bits-1:0] shadow;
  logic [cfg_bits-1:0] active;

  logic [2*ws-1:0]        tracks_in;
  logic [2*ws-1:0]        tracks_out;
  logic [3:0]             clb_bits;
  logic [num_in_sels-1:0] clb_in_all;

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      shadow <= '0;
      active <= '0;
    end else begin
      if (cen) begin
        shadow <= {shadow[cfg_bits-2:0], cfg_in};
      end
      if (cfg_set) begin
        active <= shadow;
      end
    end
  end

  assign cfg_out = shadow[cfg_bits-1];

  // Track0 sits in the low positions
  assign tracks_in = {track1_in, track0_in};

  // Output select value minus one indexes this vector
  assign clb_bits = {clb1_out[fabric_pkg::clb_out_sync], clb1_out[fabric_pkg::clb_out_comb],
                     clb0_out[fabric_pkg::clb_out_sync], clb0_out[fabric_pkg::clb_out_comb]};

  // CLB inputs, clb0 bits first then clb1
  for (genvar i = 0; i < num_in_sels; i++) begin : g_in_sel
    cb_in_sel_t sel;

    assign sel = active[i*in_sel_bits +: in_sel_bits];
    assign clb_in_all[i] = (int'(sel) < 2 * ws) ? tracks_in[sel] : 1'b0;
  end

  assign clb0_in = clb_in_all[fabric_pkg::num_luts-1:0];
  assign clb1_in = clb_in_all[num_in_sels-1:fabric_pkg::num_luts];

  // Outgoing tracks pass straight through or take a CLB output bit
  for (genvar j = 0; j < 2 * ws; j++) begin : g_out_sel
    fabric_pkg::cb_out_sel_t sel;
    logic                    drv;

    assign sel = active[out_base + j*out_sel_bits +: out_sel_bits];
    always_comb begin
      case (sel)
        3'd0:    drv = tracks_in[j];
        3'd1:    drv = clb_bits[0];
        3'd2:    drv = clb_bits[1];
        3'd3:    drv = clb_bits[2];
        3'd4:    drv = clb_bits[3];
        default: drv = 1'b0;
      endcase
    end
    assign tracks_out[j] = drv;
  end

  assign track0_out = tracks_out[ws-1:0];
  assign track1_out = tracks_out[2*ws-1:ws];

endmodule

//--- source/fabric_pkg.sv
package fabric_pkg;

  // Tile geometry
  localparam int num_luts = 4;
  localparam int num_sides = 4;

  // Configuration bits held by the logic slice
  localparam int slice_cfg_bits = 64;

  // Side indices in clockwise order
  localparam int side_north = 0;
  localparam int side_east = 1;
  localparam int side_south = 2;
  localparam int side_west = 3;

  // Bit positions inside one CLB output side
  localparam int clb_out_comb = 0;
  localparam int clb_out_sync = 1;

  // Truth table of one 4-input LUT, addressed by the four side bits
  typedef logic [15:0] lut_mask_t;

  // One CLB input side, one bit per LUT
  typedef logic [num_luts-1:0] lut_in_t;

  // One CLB output side, registered bit high and comb bit low
  typedef logic [1:0] clb_out_t;

  // Connection block track output select
  typedef logic [2:0] cb_out_sel_t;

  // Switch box output select, 0 drives zero
  typedef logic [1:0] sb_sel_t;

endpackage

//--- source/logic_slice.sv
`timescale 1ns/1ns

module logic_slice (
  input  logic                 clk,
  input  logic                 arst_n,
  input  logic                 cen,
  input  logic                 cfg_set,
  input  logic                 cfg_in,
  output logic                 cfg_out,
  input  fabric_pkg::lut_in_t  north_in,
  input  fabric_pkg::lut_in_t  east_in,
  input  fabric_pkg::lut_in_t  south_in,
  input  fabric_pkg::lut_in_t  west_in,
  output fabric_pkg::clb_out_t north_out,
  output fabric_pkg::clb_out_t east_out,
  output fabric_pkg::clb_out_t south_out,
  output fabric_pkg::clb_out_t west_out
);

  localparam int cfg_bits = fabric_pkg::slice_cfg_bits;
  localparam int mask_bits = $bits(fabric_pkg::lut_mask_t);

  logic [cfg_bits-1:0] shadow;
  logic [cfg_bits-1:0] active;

  // Inputs grouped by side index so each LUT can gather its address
  logic [fabric_pkg::num_sides-1:0][fabric_pkg::num_luts-1:0] side_in;

  logic [fabric_pkg::num_luts-1:0] lut_comb;
  logic [fabric_pkg::num_luts-1:0] lut_sync;

  // Shift chain segment and shadow to active transfer
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      shadow <= '0;
      active <= '0;
    end else begin
      if (cen) begin
        shadow <= {shadow[cfg_bits-2:0], cfg_in};
      end
      if (cfg_set) begin
        active <= shadow;
      end
    end
  end

  assign cfg_out = shadow[cfg_bits-1];

  assign side_in[fabric_pkg::side_north] = north_in;
  assign side_in[fabric_pkg::side_east] = east_in;
  assign side_in[fabric_pkg::side_south] = south_in;
  assign side_in[fabric_pkg::side_west] = west_in;

  // LUT k reads bit k of every side, the side index being the address bit
  for (genvar k = 0; k < fabric_pkg::num_luts; k++) begin : g_lut
    fabric_pkg::lut_mask_t mask;
    logic [fabric_pkg::num_sides-1:0] addr;

    assign mask = active[k*mask_bits +: mask_bits];
    for (genvar s = 0; s < fabric_pkg::num_sides; s++) begin : g_addr
      assign addr[s] = side_in[s][k];
    end
    assign lut_comb[k] = mask[addr];
  end

  // Registered outputs freeze while configuration is shifting
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      lut_sync <= '0;
    end else if (!cen) begin
      lut_sync <= lut_comb;
    end
  end

  // Side k carries LUT k
  assign north_out[fabric_pkg::clb_out_comb] = lut_comb[fabric_pkg::side_north];
  assign north_out[fabric_pkg::clb_out_sync] = lut_sync[fabric_pkg::side_north];
  assign east_out[fabric_pkg::clb_out_comb] = lut_comb[fabric_pkg::side_east];
  assign east_out[fabric_pkg::clb_out_sync] = lut_sync[fabric_pkg::side_east];
  assign south_out[fabric_pkg::clb_out_comb] = lut_comb[fabric_pkg::side_south];
  assign south_out[fabric_pkg::clb_out_sync] = lut_sync[fabric_pkg::side_south];
  assign west_out[fabric_pkg::clb_out_comb] = lut_comb[fabric_pkg::side_west];
  assign west_out[fabric_pkg::clb_out_sync] = lut_sync[fabric_pkg::side_west];

endmodule

//--- source/switch_box.sv
`timescale 1ns/1ns

module switch_box #(
  parameter int ws = 4
) (
  input  logic          clk,
  input  logic          arst_n,
  input  logic          cen,
  input  logic          cfg_set,
  input  logic          cfg_in,
  output logic          cfg_out,
  input  logic [ws-1:0] north_in,
  input  logic [ws-1:0] east_in,
  input  logic [ws-1:0] south_in,
  input  logic [ws-1:0] west_in,
  output logic [ws-1:0] north_out,
  output logic [ws-1:0] east_out,
  output logic [ws-1:0] south_out,
  output logic [ws-1:0] west_out
);

  localparam int sel_bits = $bits(fabric_pkg::sb_sel_t);
  localparam int cfg_bits = fabric_pkg::num_sides * ws * sel_bits;

  logic [cfg_bits-1:0] shadow;
  logic [cfg_bits-1:0] active;

  logic [fabric_pkg::num_sides-1:0][ws-1:0] side_in;
  logic [fabric_pkg::num_sides-1:0][ws-1:0] side_out;

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      shadow <= '0;
      active <= '0;
    end else begin
      if (cen) begin
        shadow <= {shadow[cfg_bits-2:0], cfg_in};
      end
      if (cfg_set) begin
        active <= shadow;
      end
    end
  end

  assign cfg_out = shadow[cfg_bits-1];

  assign side_in[fabric_pkg::side_north] = north_in;
  assign side_in[fabric_pkg::side_east] = east_in;
  assign side_in[fabric_pkg::side_south] = south_in;
  assign side_in[fabric_pkg::side_west] = west_in;

  // Disjoint pattern, select n takes the side n steps clockwise on the same index
  for (genvar s = 0; s < fabric_pkg::num_sides; s++) begin : g_side
    for (genvar t = 0; t < ws; t++) begin : g_track
      fabric_pkg::sb_sel_t sel;

      assign sel = active[(s*ws + t)*sel_bits +: sel_bits];
      assign side_out[s][t] = (sel == '0) ? 1'b0 :
                              side_in[(s + int'(sel)) % fabric_pkg::num_sides][t];
    end
  end

  assign north_out = side_out[fabric_pkg::side_north];
  assign east_out = side_out[fabric_pkg::side_east];
  assign south_out = side_out[fabric_pkg::side_south];
  assign west_out = side_out[fabric_pkg::side_west];

endmodule

//--- testbench/clb_tile_asserts.sv
`timescale 1ns/1ns

module clb_tile_asserts #(
  parameter int ws = 4
) (
  input logic             clk,
  input logic             arst_n,
  input logic             cen,
  input logic             cfg_set,
  input logic             cfg_out,
  input logic [1:0]       sync_bits,
  input logic [4*ws+11:0] ins,
  input logic [4*ws+11:0] outs
);

  logic [4*ws+11:0] ins_prev;
  int quiet_edges;

  // Edges in a row with no shift, no strobe and unchanged inputs
  always @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      ins_prev <= '0;
      quiet_edges <= 0;
    end else begin
      ins_prev <= ins;
      if (cen || cfg_set || ins != ins_prev) begin
        quiet_edges <= 0;
      end else if (quiet_edges < 3) begin
        quiet_edges <= quiet_edges + 1;
      end
    end
  end

  a_cfg_out_reset: assert property (@(posedge clk) !arst_n |-> !cfg_out)
    else $error("cfg_out is high during reset");

  a_sync_hold: assert property (@(posedge clk) disable iff (!arst_n)
    cen |=> $stable(sync_bits))
    else $error("registered LUT outputs moved across a shift edge");

  a_steady: assert property (@(posedge clk) disable iff (!arst_n)
    (quiet_edges >= 2 && !cen && !cfg_set && ins == ins_prev) |-> $stable(outs))
    else $error("tile outputs changed with steady inputs and configuration");

endmodule

bind clb_tile clb_tile_asserts #(.ws(ws)) asserts0 (
  .clk(clk), .arst_n(arst_n), .cen(cen), .cfg_set(cfg_set), .cfg_out(cfg_out),
  .sync_bits({clb_south_out[1], clb_west_out[1]}),
  .ins({north_single_in, east_single_in, south_single_in, west_single_in,
        cb_north_in, cb_east_in, clb_south_in, clb_west_in}),
  .outs({north_single_out, east_single_out, south_single_out, west_single_out,
         cb_north_out, cb_east_out, clb_south_out, clb_west_out})
);

//--- testbench/clb_tile_tb.sv
`timescale 1ns/1ns

module clb_tile_tb;

  localparam int ws = 4;
  localparam int chain_bits = 192;
  // Eight loads of about 200 cycles, the data phases and some margin
  localparam int max_cycles = 8 * 200 + 400 + 200;

  logic clk;
  logic arst_n;
  logic cen;
  logic cfg_set;
  logic cfg_in;
  logic cfg_out;

  // Inputs from bit 0 are north, east, south, west tracks, cb_north_in,
  // cb_east_in, clb_south_in and clb_west_in
  logic [27:0] in_vec;
  logic [27:0] dut_out;
  logic [27:0] held;

  logic [ws-1:0] north_single_out;
  logic [ws-1:0] east_single_out;
  logic [ws-1:0] south_single_out;
  logic [ws-1:0] west_single_out;
  fabric_pkg::lut_in_t cb_north_out;
  fabric_pkg::lut_in_t cb_east_out;
  fabric_pkg::clb_out_t clb_south_out;
  fabric_pkg::clb_out_t clb_west_out;

  logic [chain_bits-1:0] img;
  logic [chain_bits-1:0] shadow_img;
  logic [chain_bits-1:0] active_img;
  logic [3:0] sync_model;
  logic [31:0] exp_now;
  integer seed;
  int cycles;

  clb_tile #(.ws(ws)) dut0 (
    .clk(clk), .arst_n(arst_n), .cen(cen), .cfg_set(cfg_set),
    .cfg_in(cfg_in), .cfg_out(cfg_out),
    .north_single_in(in_vec[3:0]), .east_single_in(in_vec[7:4]),
    .south_single_in(in_vec[11:8]), .west_single_in(in_vec[15:12]),
    .north_single_out(north_single_out), .east_single_out(east_single_out),
    .south_single_out(south_single_out), .west_single_out(west_single_out),
    .cb_north_in(in_vec[17:16]), .cb_east_in(in_vec[19:18]),
    .cb_north_out(cb_north_out), .cb_east_out(cb_east_out),
    .clb_south_in(in_vec[23:20]), .clb_west_in(in_vec[27:24]),
    .clb_south_out(clb_south_out), .clb_west_out(clb_west_out)
  );

  assign dut_out = {clb_west_out, clb_south_out, cb_east_out, cb_north_out,
                    west_single_out, south_single_out, east_single_out, north_single_out};

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  // Result bits 3:0 track0 out, 7:4 track1 out, 11:8 clb0 in, 15:12 clb1 in
  function automatic logic [15:0] cb_eval(input logic [47:0] cfg, input logic [3:0] t0,
                                          input logic [3:0] t1, input logic [1:0] c0,
                                          input logic [1:0] c1);
    logic [7:0] trk;
    logic [3:0] clb_bits;
    logic [7:0] clb_in;
    logic [7:0] trk_out;
    logic [2:0] sel;
    trk = {t1, t0};
    clb_bits = {c1, c0};
    for (int i = 0; i < 8; i++) begin
      clb_in[i] = trk[cfg[i*3 +: 3]];
    end
    for (int j = 0; j < 8; j++) begin
      sel = cfg[24 + j*3 +: 3];
      trk_out[j] = (sel == 3'd0) ? trk[j] : (sel <= 3'd4) ? clb_bits[sel - 1] : 1'b0;
    end
    return {clb_in, trk_out};
  endfunction

  // Sides packed north, east, south, west from bit 0
  function automatic logic [15:0] sb_eval(input logic [31:0] cfg, input logic [15:0] sides);
    logic [15:0] res;
    logic [1:0] sel;
    for (int s = 0; s < 4; s++) begin
      for (int t = 0; t < 4; t++) begin
        sel = cfg[(s*4 + t)*2 +: 2];
        res[s*4 + t] = (sel == 2'd0) ? 1'b0 : sides[((s + sel) % 4)*4 + t];
      end
    end
    return res;
  endfunction

  // Expected tile outputs in bits 27:0 and the four LUT comb values on top
  function automatic logic [31:0] tile_model(input logic [191:0] cfg, input logic [27:0] iv,
                                             input logic [3:0] sync);
    logic [15:0] cbn;
    logic [15:0] cbe;
    logic [15:0] sbo;
    logic [3:0] comb;
    logic [3:0] addr;
    cbn = '0;
    cbe = '0;
    sbo = '0;
    comb = '0;
    // Repeated evaluation lets the loop-free network settle
    for (int iter = 0; iter < 6; iter++) begin
      for (int k = 0; k < 4; k++) begin
        addr = {iv[24+k], iv[20+k], cbe[8+k], cbn[8+k]};
        comb[k] = cfg[k*16 + addr];
      end
      sbo = sb_eval(cfg[143:112], {cbn[7:4], cbe[7:4], iv[7:0]});
      cbn = cb_eval(cfg[111:64], iv[15:12], sbo[15:12], {sync[0], comb[0]}, iv[17:16]);
      cbe = cb_eval(cfg[191:144], iv[11:8], sbo[11:8], {sync[1], comb[1]}, iv[19:18]);
    end
    return {comb, sync[3], comb[3], sync[2], comb[2], cbe[15:12], cbn[15:12],
            cbn[3:0], cbe[3:0], sbo[7:4], sbo[3:0]};
  endfunction

  task automatic expect_equal(input logic [31:0] got, input logic [31:0] want,
                              input string what);
    if (got !== want) begin
      $display("mismatch at %0t ns: %s is %h, expected %h", $time, what, got, want);
      $display("Checks failed");
      $fatal(1, "stopping at the first mismatch");
    end
  endtask

  // CLB inputs read track0 only and track1 outputs carry CLB bits, so no loop forms
  task automatic random_image(output logic [191:0] image);
    int base;
    logic [2:0] sel;
    image = {$random(seed), $random(seed), $random(seed),
             $random(seed), $random(seed), $random(seed)};
    for (int c = 0; c < 2; c++) begin
      base = (c == 0) ? 64 : 144;
      for (int i = 0; i < 8; i++) begin
        image[base + i*3 + 2] = 1'b0;
      end
      for (int j = 0; j < 8; j++) begin
        sel = image[base + 24 + j*3 +: 3];
        sel = (j < 4) ? sel % 5 : 3'd1 + sel % 4;
        image[base + 24 + j*3 +: 3] = sel;
      end
    end
  endtask

  // Top bit first, so bit 0 lands in the slice's lowest shadow bit
  task automatic shift_image(input logic [191:0] image, input bit vary_inputs);
    for (int i = chain_bits - 1; i >= 0; i--) begin
      @(posedge clk);
      #10;
      cen = 1'b1;
      cfg_in = image[i];
      if (vary_inputs) begin
        in_vec = $random(seed);
      end
    end
    @(posedge clk);
    #10;
    cen = 1'b0;
  endtask

  task automatic strobe_config;
    cfg_set = 1'b1;
    @(posedge clk);
    #10;
    cfg_set = 1'b0;
  endtask

  task automatic drive_data(input int n);
    for (int i = 0; i < n; i++) begin
      @(posedge clk);
      #10;
      // Second half keeps inputs steady over several edges
      if (i < n / 2 || i % 6 == 0) begin
        in_vec = $random(seed);
      end
    end
  endtask

  // Shadow, active and registered LUT state as the tile rules give it
  always @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      shadow_img <= '0;
      active_img <= '0;
      sync_model <= '0;
    end else begin
      if (cen) begin
        shadow_img <= {shadow_img[chain_bits-2:0], cfg_in};
      end
      if (cfg_set) begin
        active_img <= shadow_img;
      end
      if (!cen) begin
        sync_model <= exp_now[31:28];
      end
    end
  end

  always @(negedge clk) begin
    exp_now = tile_model(active_img, in_vec, sync_model);
    if (cycles > 0) begin
      expect_equal(cfg_out, shadow_img[chain_bits-1], "cfg_out");
      expect_equal(north_single_out, exp_now[3:0], "north_single_out");
      expect_equal(east_single_out, exp_now[7:4], "east_single_out");
      expect_equal(south_single_out, exp_now[11:8], "south_single_out");
      expect_equal(west_single_out, exp_now[15:12], "west_single_out");
      expect_equal(cb_north_out, exp_now[19:16], "cb_north_out");
      expect_equal(cb_east_out, exp_now[23:20], "cb_east_out");
      expect_equal(clb_south_out, exp_now[25:24], "clb_south_out");
      expect_equal(clb_west_out, exp_now[27:26], "clb_west_out");
    end
  end

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles >= max_cycles) begin
      $display("timeout, the test sequence did not finish within %0d cycles", max_cycles);
      $display("Checks failed");
      $fatal(1, "simulation timeout");
    end
  end

  initial begin
    seed = 32'he164;
    cycles = 0;
    arst_n = 1'b0;
    cen = 1'b0;
    cfg_set = 1'b0;
    cfg_in = 1'b0;
    in_vec = $random(seed);
    repeat (3) @(posedge clk);
    #10;
    arst_n = 1'b1;
    // Reset configuration first, then random images
    drive_data(8);
    for (int n = 0; n < 6; n++) begin
      random_image(img);
      shift_image(img, 1'b1);
      strobe_config();
      drive_data(48);
    end
    random_image(img);
    @(posedge clk);
    #10;
    // Model outputs for the active image before the new one is shifted in
    held = exp_now[27:0];
    shift_image(img, 1'b0);
    expect_equal(dut_out, held, "outputs before cfg_set");
    strobe_config();
    drive_data(48);
    $display("All checks passed");
    $finish;
  end

endmodule
